// ==== include/pet_bus_settings.svh ====
// ----------------------------------------------------------
// Build-time constants for the CPU bus-slot block
// Included by the package and by RTL that needs raw numbers
// ----------------------------------------------------------
`ifndef PET_BUS_SETTINGS_SVH
`define PET_BUS_SETTINGS_SVH

// System clock rate, used for ns to cycle conversion
`define SYS_CLOCK_MHZ     64

// W65C02S datasheet figures in ns
`define CPU_TBVD_NS       30  // BE to valid data (tBVD)
`define CPU_TPWH_NS       62  // Phi2 minimum high pulse width (tPWH)
`define CPU_TDSR_NS       15  // Data setup before Phi2 falls (tDSR)
`define CPU_TDHX_NS       10  // Data hold after Phi2 falls (tDHR, tDHW)

// Bus transceiver worst-case enable delay
`define IOTX_NS           11

// One CPU slot in system clocks
`define SLOT_CYCLES       16

// Bus widths
`define CPU_ADDR_WIDTH    16
`define CPU_DATA_WIDTH    8

// Low address bits that pick a RAM word
`define RAM_ADDR_WIDTH    10

// Request queue entries, two requests per slot at most
`define FIFO_DEPTH        4

`endif

// ==== verilog/pet_bus_pkg.sv ====
// ----------------------------------------------------------
// Shared types and the ns to cycle helper for the bus block
// ----------------------------------------------------------
`default_nettype none

`include "pet_bus_settings.svh"

package pet_bus_pkg;

    typedef logic [`CPU_ADDR_WIDTH-1:0]      cpu_addr_t;    // Full CPU address
    typedef logic [`CPU_DATA_WIDTH-1:0]      cpu_data_t;    // Data byte
    typedef logic [$clog2(`SLOT_CYCLES)-1:0] slot_count_t;  // Position inside a slot
    typedef logic [`RAM_ADDR_WIDTH-1:0]      ram_addr_t;    // RAM word address

    // RAM port sequencer
    typedef enum logic [1:0] {
        RAM_IDLE,    // Waiting for a queued request
        RAM_ACCESS,  // One read or write on the array
        RAM_DONE     // Settle cycle before going idle
    } ram_state_t;

    // Ceiling of ns over clock period, plus one cycle for trace delay
    function automatic int ns_to_cycles(input int time_ns);
        return (time_ns * `SYS_CLOCK_MHZ + 999) / 1000 + 1;
    endfunction

endpackage

`default_nettype wire

// ==== verilog/cpu_timing.sv ====
// ----------------------------------------------------------
// Slot counter that paces one CPU bus cycle per 16 clocks
// Drives BE, Phi2, capture strobes and the RAM data windows
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "pet_bus_settings.svh"

module cpu_timing (
    input  logic sys_clock_i,
    input  logic rst_n_i,
    input  logic cpu_ready_i,    // Outside world allows a new slot
    input  logic drained_i,      // Queue empty and RAM port idle
    input  logic cpu_we_i,       // CPU write pin

    output logic cpu_be_o,
    output logic cpu_clock_o,    // Phi2
    output logic addr_strobe_o,
    output logic data_strobe_o,
    output logic cpu_rd_en_o,
    output logic cpu_wr_en_o
);

    // Datasheet times rounded up to whole system clocks
    localparam int T_BVD  = pet_bus_pkg::ns_to_cycles(`CPU_TBVD_NS);
    localparam int T_PWH  = pet_bus_pkg::ns_to_cycles(`CPU_TPWH_NS);
    localparam int T_DSR  = pet_bus_pkg::ns_to_cycles(`CPU_TDSR_NS);
    localparam int T_DHX  = pet_bus_pkg::ns_to_cycles(`CPU_TDHX_NS);
    localparam int T_IOTX = pet_bus_pkg::ns_to_cycles(`IOTX_NS);

    localparam pet_bus_pkg::slot_count_t SLOT_IDLE = '0;
    localparam pet_bus_pkg::slot_count_t BE_START  = 1;

    // Address settles tBVD after BE
    localparam pet_bus_pkg::slot_count_t ADDR_VALID =
        pet_bus_pkg::slot_count_t'(int'(BE_START) + T_BVD);

    // Phi2 rises once the transceivers have turned around
    localparam pet_bus_pkg::slot_count_t PHI_START =
        pet_bus_pkg::slot_count_t'(int'(ADDR_VALID) + T_IOTX);

    // BE drops tBVD before the slot ends so the bus is free for the next one
    localparam pet_bus_pkg::slot_count_t BE_END =
        pet_bus_pkg::slot_count_t'(`SLOT_CYCLES - T_BVD);

    // Phi2 falls early enough to keep data hold inside BE
    localparam pet_bus_pkg::slot_count_t PHI_END =
        pet_bus_pkg::slot_count_t'(int'(BE_END) - T_DHX);

    // Data must be stable tDSR before Phi2 falls
    localparam pet_bus_pkg::slot_count_t DATA_VALID =
        pet_bus_pkg::slot_count_t'(int'(PHI_END) - T_DSR);

    localparam int PHI_HIGH_CYCLES = int'(PHI_END) - int'(PHI_START);

    pet_bus_pkg::slot_count_t slot_count;

    // Elaboration stops if the derived Phi2 high time is too short
    if (PHI_HIGH_CYCLES < T_PWH) begin : g_pwh_check
        $fatal(1, "Phi2 high width %0d cycles is below minimum %0d",
               PHI_HIGH_CYCLES, T_PWH);
    end

    // Slot counter parks at zero until a start is allowed
    always_ff @(posedge sys_clock_i) begin
        if (!rst_n_i) begin
            slot_count <= SLOT_IDLE;
        end else if (slot_count != SLOT_IDLE || (cpu_ready_i && drained_i)) begin
            slot_count <= slot_count + 1'b1;  // Wraps back to idle after the last cycle
        end
    end

    always_ff @(posedge sys_clock_i) begin
        if (!rst_n_i) begin
            cpu_be_o      <= 1'b0;
            cpu_clock_o   <= 1'b0;
            addr_strobe_o <= 1'b0;
            data_strobe_o <= 1'b0;
            cpu_rd_en_o   <= 1'b0;
            cpu_wr_en_o   <= 1'b0;
        end else begin
            addr_strobe_o <= 1'b0;  // Strobes are single pulses
            data_strobe_o <= 1'b0;

            case (slot_count)
                BE_START: begin
                    cpu_be_o <= 1'b1;
                end
                ADDR_VALID: begin
                    addr_strobe_o <= 1'b1;       // Address and RWB now stable
                    cpu_rd_en_o   <= !cpu_we_i;  // Open read window
                end
                PHI_START: begin
                    cpu_clock_o <= 1'b1;
                end
                DATA_VALID: begin
                    data_strobe_o <= 1'b1;       // Write data stable
                    cpu_wr_en_o   <= cpu_we_i;
                end
                PHI_END: begin
                    cpu_clock_o <= 1'b0;         // Min pulse width met
                    cpu_wr_en_o <= 1'b0;
                end
                BE_END: begin
                    cpu_be_o    <= 1'b0;         // Hold times met, release bus
                    cpu_rd_en_o <= 1'b0;
                end
                default: begin
                end
            endcase
        end
    end

    // Write window sits inside the bus enable window
    a_wr_inside_be: assert property (@(posedge sys_clock_i) disable iff (!rst_n_i)
        cpu_wr_en_o |-> cpu_be_o);

    a_addr_strobe_pulse: assert property (@(posedge sys_clock_i) disable iff (!rst_n_i)
        addr_strobe_o |=> !addr_strobe_o);

    a_data_strobe_pulse: assert property (@(posedge sys_clock_i) disable iff (!rst_n_i)
        data_strobe_o |=> !data_strobe_o);

endmodule

`default_nettype wire

// ==== verilog/bus_capture.sv ====
// ----------------------------------------------------------
// Turns slot strobes and CPU pins into request queue pushes
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "pet_bus_settings.svh"

module bus_capture (
    input  logic                   sys_clock_i,
    input  logic                   rst_n_i,
    input  logic                   addr_strobe_i,
    input  logic                   data_strobe_i,
    input  logic                   cpu_we_i,
    input  pet_bus_pkg::cpu_addr_t cpu_addr_i,
    input  pet_bus_pkg::cpu_data_t cpu_din_i,

    output logic                   push_o,      // One-cycle push into the queue
    output logic                   req_we_o,
    output pet_bus_pkg::ram_addr_t req_addr_o,
    output pet_bus_pkg::cpu_data_t req_data_o
);

    logic wr_pending;  // Write seen at address strobe, data still to come

    always_ff @(posedge sys_clock_i) begin
        if (!rst_n_i) begin
            push_o     <= 1'b0;
            wr_pending <= 1'b0;
        end else begin
            push_o <= 1'b0;
            if (addr_strobe_i) begin
                wr_pending <= cpu_we_i;
                push_o     <= !cpu_we_i;  // Reads go out right away
            end else if (data_strobe_i && wr_pending) begin
                wr_pending <= 1'b0;
                push_o     <= 1'b1;
            end
        end
    end

    // Request payload, address doubles as the latch for the slot
    always_ff @(posedge sys_clock_i) begin
        if (addr_strobe_i) begin
            req_addr_o <= cpu_addr_i[`RAM_ADDR_WIDTH-1:0];  // Upper bits alias
            req_we_o   <= cpu_we_i;
        end
        if (data_strobe_i && wr_pending) begin
            req_data_o <= cpu_din_i;
        end
    end

    // One read and one write push at most in any slot
    a_one_read_per_slot: assert property (@(posedge sys_clock_i) disable iff (!rst_n_i)
        (push_o && !req_we_o) |=> !(push_o && !req_we_o) [*(`SLOT_CYCLES - 1)]);

    a_one_write_per_slot: assert property (@(posedge sys_clock_i) disable iff (!rst_n_i)
        (push_o && req_we_o) |=> !(push_o && req_we_o) [*(`SLOT_CYCLES - 1)]);

endmodule

`default_nettype wire

// ==== verilog/req_fifo.sv ====
// ----------------------------------------------------------
// Small request queue between bus capture and the RAM port
// Head entry is shown combinationally, pop advances it
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "pet_bus_settings.svh"

module req_fifo (
    input  logic                   sys_clock_i,
    input  logic                   rst_n_i,
    input  logic                   push_i,
    input  logic                   we_i,
    input  pet_bus_pkg::ram_addr_t addr_i,
    input  pet_bus_pkg::cpu_data_t data_i,
    input  logic                   pop_i,

    output logic                   empty_o,
    output logic                   head_we_o,
    output pet_bus_pkg::ram_addr_t head_addr_o,
    output pet_bus_pkg::cpu_data_t head_data_o
);

    localparam int PTR_W = $clog2(`FIFO_DEPTH);
    localparam int CNT_W = $clog2(`FIFO_DEPTH + 1);

    logic                   we_mem   [`FIFO_DEPTH];
    pet_bus_pkg::ram_addr_t addr_mem [`FIFO_DEPTH];
    pet_bus_pkg::cpu_data_t data_mem [`FIFO_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;

    assign empty_o = (count == '0);
    assign full    = (count == CNT_W'(`FIFO_DEPTH));

    // Head of queue straight to the RAM port
    assign head_we_o   = we_mem[rd_ptr];
    assign head_addr_o = addr_mem[rd_ptr];
    assign head_data_o = data_mem[rd_ptr];

    always_ff @(posedge sys_clock_i) begin
        if (!rst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr <= (wr_ptr == PTR_W'(`FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop_i) begin
                rd_ptr <= (rd_ptr == PTR_W'(`FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push_i, pop_i})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Both or neither
            endcase
        end
    end

    always_ff @(posedge sys_clock_i) begin
        if (push_i) begin
            we_mem[wr_ptr]   <= we_i;
            addr_mem[wr_ptr] <= addr_i;
            data_mem[wr_ptr] <= data_i;
        end
    end

    a_no_overflow: assert property (@(posedge sys_clock_i) disable iff (!rst_n_i)
        push_i |-> !full);

    a_no_underflow: assert property (@(posedge sys_clock_i) disable iff (!rst_n_i)
        pop_i |-> !empty_o);

endmodule

`default_nettype wire

// ==== verilog/ram_port.sv ====
// ----------------------------------------------------------
// Runs queued requests on on-chip RAM, keeps last read byte
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "pet_bus_settings.svh"

module ram_port (
    input  logic                   sys_clock_i,
    input  logic                   rst_n_i,
    input  logic                   empty_i,
    input  logic                   head_we_i,
    input  pet_bus_pkg::ram_addr_t head_addr_i,
    input  pet_bus_pkg::cpu_data_t head_data_i,

    output logic                   pop_o,
    output logic                   drained_o,   // Nothing queued or in flight
    output pet_bus_pkg::cpu_data_t rd_data_o    // Held until the next read
);

    pet_bus_pkg::cpu_data_t mem [2**`RAM_ADDR_WIDTH];

    pet_bus_pkg::ram_state_t state_q;

    // Request taken off the queue
    logic                   req_we_q;
    pet_bus_pkg::ram_addr_t req_addr_q;
    pet_bus_pkg::cpu_data_t req_data_q;

    assign pop_o     = (state_q == pet_bus_pkg::RAM_IDLE) && !empty_i;
    assign drained_o = (state_q == pet_bus_pkg::RAM_IDLE) && empty_i;

    always_ff @(posedge sys_clock_i) begin
        if (!rst_n_i) begin
            state_q   <= pet_bus_pkg::RAM_IDLE;
            rd_data_o <= '0;
        end else begin
            case (state_q)
                pet_bus_pkg::RAM_IDLE: begin
                    if (!empty_i) state_q <= pet_bus_pkg::RAM_ACCESS;
                end
                pet_bus_pkg::RAM_ACCESS: begin
                    if (!req_we_q) rd_data_o <= mem[req_addr_q];  // Read lands here
                    state_q <= pet_bus_pkg::RAM_DONE;
                end
                default: begin
                    state_q <= pet_bus_pkg::RAM_IDLE;
                end
            endcase
        end
    end

    // Latch head as it is popped
    always_ff @(posedge sys_clock_i) begin
        if (pop_o) begin
            req_we_q   <= head_we_i;
            req_addr_q <= head_addr_i;
            req_data_q <= head_data_i;
        end
    end

    always_ff @(posedge sys_clock_i) begin
        if (state_q == pet_bus_pkg::RAM_ACCESS && req_we_q) begin
            mem[req_addr_q] <= req_data_q;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/pet_bus_top.sv ====
// ----------------------------------------------------------
// CPU bus-slot block, timing and capture feed a queue
// that the RAM port drains before the next slot starts
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module pet_bus_top (
    input  logic                   sys_clock_i,
    input  logic                   rst_n_i,
    input  logic                   cpu_ready_i,  // Permission to start a slot
    input  logic                   cpu_we_i,
    input  pet_bus_pkg::cpu_addr_t cpu_addr_i,
    input  pet_bus_pkg::cpu_data_t cpu_din_i,    // CPU write data

    output logic                   cpu_be_o,
    output logic                   cpu_clock_o,
    output logic                   cpu_rd_en_o,
    output logic                   cpu_wr_en_o,
    output pet_bus_pkg::cpu_data_t cpu_dout_o    // Read data toward the CPU
);

    logic drained;
    logic addr_strobe;
    logic data_strobe;

    // Capture to queue
    logic                   push;
    logic                   req_we;
    pet_bus_pkg::ram_addr_t req_addr;
    pet_bus_pkg::cpu_data_t req_data;

    // Queue to RAM port
    logic                   pop;
    logic                   empty;
    logic                   head_we;
    pet_bus_pkg::ram_addr_t head_addr;
    pet_bus_pkg::cpu_data_t head_data;

    cpu_timing u_timing (
        .sys_clock_i   (sys_clock_i),
        .rst_n_i       (rst_n_i),
        .cpu_ready_i   (cpu_ready_i),
        .drained_i     (drained),
        .cpu_we_i      (cpu_we_i),
        .cpu_be_o      (cpu_be_o),
        .cpu_clock_o   (cpu_clock_o),
        .addr_strobe_o (addr_strobe),
        .data_strobe_o (data_strobe),
        .cpu_rd_en_o   (cpu_rd_en_o),
        .cpu_wr_en_o   (cpu_wr_en_o)
    );

    bus_capture u_capture (
        .sys_clock_i   (sys_clock_i),
        .rst_n_i       (rst_n_i),
        .addr_strobe_i (addr_strobe),
        .data_strobe_i (data_strobe),
        .cpu_we_i      (cpu_we_i),
        .cpu_addr_i    (cpu_addr_i),
        .cpu_din_i     (cpu_din_i),
        .push_o        (push),
        .req_we_o      (req_we),
        .req_addr_o    (req_addr),
        .req_data_o    (req_data)
    );

    req_fifo u_fifo (
        .sys_clock_i (sys_clock_i),
        .rst_n_i     (rst_n_i),
        .push_i      (push),
        .we_i        (req_we),
        .addr_i      (req_addr),
        .data_i      (req_data),
        .pop_i       (pop),
        .empty_o     (empty),
        .head_we_o   (head_we),
        .head_addr_o (head_addr),
        .head_data_o (head_data)
    );

    ram_port u_ram (
        .sys_clock_i (sys_clock_i),
        .rst_n_i     (rst_n_i),
        .empty_i     (empty),
        .head_we_i   (head_we),
        .head_addr_i (head_addr),
        .head_data_i (head_data),
        .pop_o       (pop),
        .drained_o   (drained),
        .rd_data_o   (cpu_dout_o)  // Valid from the middle of a read slot
    );

endmodule

`default_nettype wire

// ==== bench/pet_bus_tb.sv ====
// ----------------------------------------------------------
// Testbench for the bus-slot block, plays the CPU pins
// Runs a table of reads and writes against a RAM model
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "pet_bus_settings.svh"

module pet_bus_tb;

    localparam int NUM_ENTRIES     = 24;
    localparam int MAX_READY_DELAY = 20;
    localparam int RESET_CYCLES    = 16;
    localparam int RANDOM_SEED     = 91625;
    localparam int TIMEOUT_CYCLES  = NUM_ENTRIES * (`SLOT_CYCLES + MAX_READY_DELAY) + 200;

    // Slot points at 64 MHz, counted from the edge that starts the slot
    localparam int BE_START   = 1;
    localparam int ADDR_VALID = 4;
    localparam int PHI_START  = 6;
    localparam int READ_VALID = 8;   // Read data back on the pins
    localparam int DATA_VALID = 9;
    localparam int PHI_END    = 11;
    localparam int BE_END     = 13;

    logic                   sys_clock_i;
    logic                   rst_n_i;
    logic                   cpu_ready_i;
    logic                   cpu_we_i;
    pet_bus_pkg::cpu_addr_t cpu_addr_i;
    pet_bus_pkg::cpu_data_t cpu_din_i;
    logic                   cpu_be_o;
    logic                   cpu_clock_o;
    logic                   cpu_rd_en_o;
    logic                   cpu_wr_en_o;
    pet_bus_pkg::cpu_data_t cpu_dout_o;

    // Stimulus table, one CPU slot per entry
    int                     tbl_delay [NUM_ENTRIES];  // Idle cycles with ready low
    logic                   tbl_we    [NUM_ENTRIES];
    pet_bus_pkg::cpu_addr_t tbl_addr  [NUM_ENTRIES];
    pet_bus_pkg::cpu_data_t tbl_data  [NUM_ENTRIES];
    pet_bus_pkg::cpu_data_t tbl_exp   [NUM_ENTRIES];  // Byte a read must return
    int                     tbl_len = 0;

    pet_bus_pkg::cpu_data_t model_mem [2**`RAM_ADDR_WIDTH];  // Word-aliased RAM model
    pet_bus_pkg::ram_addr_t written_q [$];

    int cycle_count    = 0;
    int mismatch_count = 0;
    int other_errors   = 0;
    int cur_entry      = -1;
    int slot_cycle     = 0;
    int last_rise      = 0;

    pet_bus_top dut (
        .sys_clock_i (sys_clock_i),
        .rst_n_i     (rst_n_i),
        .cpu_ready_i (cpu_ready_i),
        .cpu_we_i    (cpu_we_i),
        .cpu_addr_i  (cpu_addr_i),
        .cpu_din_i   (cpu_din_i),
        .cpu_be_o    (cpu_be_o),
        .cpu_clock_o (cpu_clock_o),
        .cpu_rd_en_o (cpu_rd_en_o),
        .cpu_wr_en_o (cpu_wr_en_o),
        .cpu_dout_o  (cpu_dout_o)
    );

    always #5 sys_clock_i = ~sys_clock_i;  // 10 ns period

    always @(posedge sys_clock_i) cycle_count <= cycle_count + 1;

    task automatic next_cycle();
        @(posedge sys_clock_i);
        #1;  // Drive and sample clear of the edge
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("Mismatch %s entry %0d slot cycle %0d: got %h, expected %h",
                     name, cur_entry, slot_cycle, got, exp);
        end
    endtask

    task automatic check_data(input string name, input pet_bus_pkg::cpu_data_t got,
                              input pet_bus_pkg::cpu_data_t exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("Mismatch %s entry %0d slot cycle %0d: got %h, expected %h",
                     name, cur_entry, slot_cycle, got, exp);
        end
    endtask

    task automatic check_idle();
        check_bit("cpu_be_o", cpu_be_o, 1'b0);
        check_bit("cpu_clock_o", cpu_clock_o, 1'b0);
        check_bit("cpu_rd_en_o", cpu_rd_en_o, 1'b0);
        check_bit("cpu_wr_en_o", cpu_wr_en_o, 1'b0);
    endtask

    // Expected pins for cycle n of a slot, cycle 1 is the BE rise
    task automatic check_slot_cycle(input int idx, input int n);
        logic we;
        logic exp_rd;
        we     = tbl_we[idx];
        exp_rd = !we && (n >= ADDR_VALID) && (n < BE_END);
        slot_cycle = n;
        check_bit("cpu_be_o", cpu_be_o, (n >= BE_START) && (n < BE_END));
        check_bit("cpu_clock_o", cpu_clock_o, (n >= PHI_START) && (n < PHI_END));
        check_bit("cpu_rd_en_o", cpu_rd_en_o, exp_rd);
        check_bit("cpu_wr_en_o", cpu_wr_en_o, we && (n >= DATA_VALID) && (n < PHI_END));
        if (exp_rd && n >= READ_VALID) check_data("cpu_dout_o", cpu_dout_o, tbl_exp[idx]);
    endtask

    // Appends one slot and updates the RAM model
    task automatic add_entry(input int ready_delay, input logic we,
                             input pet_bus_pkg::cpu_addr_t addr,
                             input pet_bus_pkg::cpu_data_t data);
        pet_bus_pkg::ram_addr_t word;
        word = addr[`RAM_ADDR_WIDTH-1:0];  // Upper bits are ignored by the RAM
        tbl_delay[tbl_len] = ready_delay;
        tbl_we[tbl_len]    = we;
        tbl_addr[tbl_len]  = addr;
        tbl_data[tbl_len]  = data;
        if (we) begin
            model_mem[word] = data;
            written_q.push_back(word);
            tbl_exp[tbl_len] = data;
        end else begin
            tbl_exp[tbl_len] = model_mem[word];
        end
        tbl_len++;
    endtask

    task automatic build_table();
        pet_bus_pkg::cpu_addr_t rd_addr;
        int k;
        add_entry(4 + int'($urandom % (MAX_READY_DELAY - 4)), 1'b1, 16'h0123, 8'hA5);
        add_entry(0, 1'b0, 16'h0123, 8'h00);   // Read back the first write
        add_entry(2, 1'b1, 16'h0045, 8'h3C);
        add_entry(0, 1'b1, 16'h0445, 8'hC3);   // Same word, bit 10 set
        add_entry(0, 1'b0, 16'h0045, 8'h00);
        add_entry(1, 1'b0, 16'hFC45, 8'h00);   // All upper bits set
        add_entry(3, 1'b1, 16'h03FF, 8'h7E);
        add_entry(0, 1'b0, 16'h07FF, 8'h00);
        for (k = 0; k < (NUM_ENTRIES - 8) / 2; k++) begin
            add_entry(0, 1'b1, pet_bus_pkg::cpu_addr_t'($urandom),
                      pet_bus_pkg::cpu_data_t'($urandom));
            rd_addr = pet_bus_pkg::cpu_addr_t'($urandom);
            rd_addr[`RAM_ADDR_WIDTH-1:0] = written_q[$urandom % written_q.size()];
            add_entry(0, 1'b0, rd_addr, pet_bus_pkg::cpu_data_t'($urandom));
        end
    endtask

    task automatic run_entry(input int idx);
        int n;
        int exp_gap;
        cur_entry  = idx;
        slot_cycle = 0;
        cpu_we_i   = tbl_we[idx];    // Held through the whole slot
        cpu_addr_i = tbl_addr[idx];
        cpu_din_i  = tbl_data[idx];
        repeat (tbl_delay[idx]) begin
            next_cycle();
            check_idle();            // Ready low keeps the bus quiet
        end
        cpu_ready_i = 1'b1;
        next_cycle();
        while (cpu_be_o !== 1'b1) begin
            check_idle();
            next_cycle();
        end
        // Slot start one edge after ready rises, or right at the count wrap
        exp_gap = (tbl_delay[idx] == 0) ? `SLOT_CYCLES : `SLOT_CYCLES + 1 + tbl_delay[idx];
        if (idx > 0 && cycle_count - last_rise != exp_gap) begin
            other_errors++;
            $display("Entry %0d started %0d cycles after the previous slot instead of %0d",
                     idx, cycle_count - last_rise, exp_gap);
        end
        last_rise = cycle_count;
        if (idx + 1 >= tbl_len) cpu_ready_i = 1'b0;
        else cpu_ready_i = (tbl_delay[idx + 1] == 0);  // Drop early for an idle gap
        for (n = 1; n <= `SLOT_CYCLES; n++) begin
            if (n > 1) next_cycle();
            check_slot_cycle(idx, n);
        end
    endtask

    task automatic print_counts();
        $display("Errors: %0d mismatches, %0d other failures", mismatch_count, other_errors);
    endtask

    // Watchdog on total run length
    initial begin
        wait (cycle_count >= TIMEOUT_CYCLES);
        $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        other_errors++;
        print_counts();
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        int i;
        sys_clock_i = 1'b0;
        rst_n_i     = 1'b0;
        cpu_ready_i = 1'b0;
        cpu_we_i    = 1'b0;
        cpu_addr_i  = '0;
        cpu_din_i   = '0;
        void'($urandom(RANDOM_SEED));
        build_table();
        repeat (RESET_CYCLES) @(posedge sys_clock_i);
        #1;
        rst_n_i = 1'b1;
        check_idle();
        for (i = 0; i < tbl_len; i++) begin
            run_entry(i);
        end
        print_counts();
        if (mismatch_count == 0 && other_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+include
verilog/pet_bus_pkg.sv
verilog/cpu_timing.sv
verilog/bus_capture.sv
verilog/req_fifo.sv
verilog/ram_port.sv
verilog/pet_bus_top.sv
bench/pet_bus_tb.sv

// ==== Bender.yml ====
package:
  name: pet_bus

sources:
  - include_dirs:
      - include
    files:
      - verilog/pet_bus_pkg.sv
      - verilog/cpu_timing.sv
      - verilog/bus_capture.sv
      - verilog/req_fifo.sv
      - verilog/ram_port.sv
      - verilog/pet_bus_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - bench/pet_bus_tb.sv
